//--- Bender.yml
package:
  name: relay_osc

sources:
  - files:
      - design/osc_cfg_pkg.sv
      - design/wb_map_pkg.sv
      - design/ico.sv
      - design/phase_meter.sv
      - design/lock_detector.sv
      - design/pi_regulator.sv
      - design/wb_status_regs.sv
      - design/relay_osc_top.sv
  - target: test
    files:
      - test/relay_osc_tb.sv

//--- design/ico.sv
`timescale 1ns/1ps

module ico (
	input  logic                          clk10MHz_inv,
	input  logic                          rst_n,
	input  logic [osc_cfg_pkg::INC_W-1:0] increment,
	output logic                          cycle,
	output logic                          cycle_start
);

	localparam int ACC_W = osc_cfg_pkg::ACC_W;
	localparam int INC_W = osc_cfg_pkg::INC_W;

	logic [ACC_W-1:0] acc;
	logic [ACC_W-1:0] acc_next;

	// f = increment * f_clk / 2^ACC_W
	assign acc_next = acc + {{(ACC_W - INC_W){1'b0}}, increment};

	always_ff @(posedge clk10MHz_inv) begin
		if (!rst_n) begin
			acc <= '0;
			cycle_start <= 1'b0;
		end else begin
			acc <= acc_next;
			// flags the first high clock of cycle
			cycle_start <= acc_next[ACC_W-1] & ~acc[ACC_W-1];
		end
	end

	// msb gives a 50% duty square wave
	assign cycle = acc[ACC_W-1];

	// increment < 2^(ACC_W-1) so the high half lasts at least two clocks
	a_start_single : assert property (@(posedge clk10MHz_inv) disable iff (!rst_n)
		cycle_start |=> !cycle_start)
		else $error("cycle_start high on two consecutive clocks");

endmodule

//--- design/lock_detector.sv
`timescale 1ns/1ps

module lock_detector #(
	parameter int THETA_UPPER = osc_cfg_pkg::THETA_UPPER,
	parameter int THETA_LOWER = osc_cfg_pkg::THETA_LOWER
) (
	input  logic                                   clk10MHz_inv,
	input  logic                                   rst_n,
	input  logic signed [osc_cfg_pkg::THETA_W-1:0] theta,
	input  logic                                   theta_valid,
	output logic                                   locked
);

	localparam int THETA_W = osc_cfg_pkg::THETA_W;

	logic [THETA_W-1:0] mag;

	// magnitude, -2^(W-1) maps to 2^(W-1) unsigned
	assign mag = theta[THETA_W-1] ? (~theta + 1'b1) : theta;

	// comparator with hysteresis
	// below lower -> lock, at or above upper -> unlock, between -> hold
	always_ff @(posedge clk10MHz_inv) begin
		if (!rst_n) begin
			locked <= 1'b0;
		end else if (theta_valid) begin
			if (mag < THETA_LOWER)
				locked <= 1'b1;
			else if (mag >= THETA_UPPER)
				locked <= 1'b0;
		end
	end

	// flag moves only once per oscillator period
	a_lock_on_valid : assert property (@(posedge clk10MHz_inv) disable iff (!rst_n)
		$changed(locked) |-> $past(theta_valid))
		else $error("locked changed without theta_valid");

endmodule

//--- design/osc_cfg_pkg.sv
package osc_cfg_pkg;

	// phase accumulator width, msb is the drive command
	localparam int ACC_W = 24;
	// tuning word width
	localparam int INC_W = 15;
	// signed phase count width
	localparam int THETA_W = 10;
	// update divider counter width
	localparam int UPD_W = 8;

	// about 14.4 kHz at 10 MHz, 695 clocks per period
	localparam logic [INC_W-1:0] START_POINT = 15'd24140;

	// hysteresis thresholds in clocks of phase error
	localparam int THETA_UPPER = 40;
	localparam int THETA_LOWER = 16;

	// oscillator periods per regulator step
	localparam logic [UPD_W-1:0] UPDATE_CYCLES = 8'd4;
	// integral gain, theta >>> I_SHIFT per step
	localparam int I_SHIFT = 2;

endpackage

//--- design/phase_meter.sv
`timescale 1ns/1ps

module phase_meter (
	input  logic                                   clk10MHz_inv,
	input  logic                                   rst_n,
	input  logic                                   cycle,
	input  logic                                   cycle_start,
	input  logic                                   current_sign,
	output logic signed [osc_cfg_pkg::THETA_W-1:0] theta,
	output logic                                   theta_valid
);

	localparam int THETA_W = osc_cfg_pkg::THETA_W;
	// saturation limits of the count
	localparam logic signed [THETA_W-1:0] CNT_MAX = {1'b0, {(THETA_W - 1){1'b1}}};
	localparam logic signed [THETA_W-1:0] CNT_MIN = {1'b1, {(THETA_W - 1){1'b0}}};

	logic sign_meta;
	logic sign_sync;
	logic cycle_d1;
	logic cycle_d2;
	logic signed [THETA_W-1:0] count;

	// current sign comes from an external comparator
	// two flops against metastability
	// drive delayed by the same depth so both line up
	always_ff @(posedge clk10MHz_inv) begin
		if (!rst_n) begin
			sign_meta <= 1'b0;
			sign_sync <= 1'b0;
			cycle_d1 <= 1'b0;
			cycle_d2 <= 1'b0;
		end else begin
			sign_meta <= current_sign;
			sign_sync <= sign_meta;
			cycle_d1 <= cycle;
			cycle_d2 <= cycle_d1;
		end
	end

	// +1 per clock of agreement, -1 per clock of disagreement
	// only during the high half of the drive
	always_ff @(posedge clk10MHz_inv) begin
		if (!rst_n) begin
			count <= '0;
			theta <= '0;
			theta_valid <= 1'b0;
		end else begin
			theta_valid <= cycle_start;
			if (cycle_start) begin
				// delayed drive is low here, previous window is complete
				theta <= count;
				count <= '0;
			end else if (cycle_d2) begin
				if (sign_sync && count != CNT_MAX)
					count <= count + 1'b1;
				else if (!sign_sync && count != CNT_MIN)
					count <= count - 1'b1;
			end
		end
	end

	a_valid_after_start : assert property (@(posedge clk10MHz_inv) disable iff (!rst_n)
		theta_valid |-> $past(cycle_start))
		else $error("theta_valid without a preceding cycle_start");

endmodule

//--- design/pi_regulator.sv
`timescale 1ns/1ps

module pi_regulator #(
	parameter logic [osc_cfg_pkg::INC_W-1:0] START_POINT = osc_cfg_pkg::START_POINT,
	parameter logic [osc_cfg_pkg::UPD_W-1:0] UPDATE_CYCLES = osc_cfg_pkg::UPDATE_CYCLES,
	parameter int I_SHIFT = osc_cfg_pkg::I_SHIFT
) (
	input  logic                                   clk10MHz_inv,
	input  logic                                   rst_n,
	input  logic signed [osc_cfg_pkg::THETA_W-1:0] theta,
	input  logic                                   theta_valid,
	input  logic                                   run,
	input  logic                                   setpoint_load,
	input  logic [osc_cfg_pkg::INC_W-1:0]          setpoint,
	output logic [osc_cfg_pkg::INC_W-1:0]          increment
);

	localparam int INC_W = osc_cfg_pkg::INC_W;
	localparam int THETA_W = osc_cfg_pkg::THETA_W;
	localparam int UPD_W = osc_cfg_pkg::UPD_W;
	// two guard bits for under and overflow
	localparam int SUM_W = INC_W + 2;

	logic [UPD_W-1:0] upd_cnt;
	logic upd_hit;
	logic [INC_W-1:0] acc;
	logic signed [THETA_W-1:0] theta_step;
	logic signed [SUM_W-1:0] sum;
	logic [INC_W-1:0] acc_sat;

	// every UPDATE_CYCLES-th phase result
	assign upd_hit = theta_valid && (upd_cnt == UPDATE_CYCLES - 1'b1);

	// integral gain as arithmetic shift
	assign theta_step = theta >>> I_SHIFT;
	assign sum = $signed({2'b00, acc})
		+ $signed({{(SUM_W - THETA_W){theta_step[THETA_W-1]}}, theta_step});

	// clamp into the tuning word range
	assign acc_sat = sum[SUM_W-1] ? '0 : (sum[SUM_W-2] ? '1 : sum[INC_W-1:0]);

	// divider restarts whenever regulation is off
	always_ff @(posedge clk10MHz_inv) begin
		if (!rst_n || !run)
			upd_cnt <= '0;
		else if (upd_hit)
			upd_cnt <= '0;
		else if (theta_valid)
			upd_cnt <= upd_cnt + 1'b1;
	end

	// positive theta means current in phase, raise the frequency
	always_ff @(posedge clk10MHz_inv) begin
		if (!rst_n) begin
			acc <= START_POINT;
			increment <= START_POINT;
		end else begin
			if (setpoint_load || !run)
				acc <= setpoint;
			else if (upd_hit)
				acc <= acc_sat;
			// tuning word one clock behind the accumulator
			increment <= run ? acc : setpoint;
		end
	end

	// open loop holds the set-point until a new one is written
	a_hold_open_loop : assert property (@(posedge clk10MHz_inv) disable iff (!rst_n)
		(!$past(run) && !$past(run, 2) && !$past(setpoint_load)) |-> $stable(increment))
		else $error("increment moved while run is low");

endmodule

//--- design/relay_osc_top.sv
`timescale 1ns/1ps

module relay_osc_top #(
	parameter logic [osc_cfg_pkg::INC_W-1:0] START_POINT = osc_cfg_pkg::START_POINT,
	parameter int THETA_UPPER = osc_cfg_pkg::THETA_UPPER,
	parameter int THETA_LOWER = osc_cfg_pkg::THETA_LOWER,
	parameter logic [osc_cfg_pkg::UPD_W-1:0] UPDATE_CYCLES = osc_cfg_pkg::UPDATE_CYCLES,
	parameter int I_SHIFT = osc_cfg_pkg::I_SHIFT
) (
	input  logic                         clk10MHz_inv,
	input  logic                         rst_n,
	input  logic                         current_sign,
	output logic                         cycle,
	output logic                         locked,
	input  logic                         wb_cyc,
	input  logic                         wb_stb,
	input  logic                         wb_we,
	input  logic [wb_map_pkg::ADR_W-1:0] wb_adr,
	input  logic [wb_map_pkg::DAT_W-1:0] wb_wdata,
	output logic [wb_map_pkg::DAT_W-1:0] wb_rdata,
	output logic                         wb_ack
);

	logic cycle_start;
	logic signed [osc_cfg_pkg::THETA_W-1:0] theta;
	logic theta_valid;
	logic [osc_cfg_pkg::INC_W-1:0] increment;
	logic run;
	logic [osc_cfg_pkg::INC_W-1:0] setpoint;
	logic setpoint_load;

	// oscillator, retuned by the regulator
	ico ico_i (
		.clk10MHz_inv(clk10MHz_inv), .rst_n(rst_n), .increment(increment),
		.cycle(cycle), .cycle_start(cycle_start)
	);

	// one phase result per period
	phase_meter phase_meter_i (
		.clk10MHz_inv(clk10MHz_inv), .rst_n(rst_n), .cycle(cycle),
		.cycle_start(cycle_start), .current_sign(current_sign),
		.theta(theta), .theta_valid(theta_valid)
	);

	lock_detector #(.THETA_UPPER(THETA_UPPER), .THETA_LOWER(THETA_LOWER)) lock_detector_i (
		.clk10MHz_inv(clk10MHz_inv), .rst_n(rst_n), .theta(theta),
		.theta_valid(theta_valid), .locked(locked)
	);

	pi_regulator #(
		.START_POINT(START_POINT), .UPDATE_CYCLES(UPDATE_CYCLES), .I_SHIFT(I_SHIFT)
	) pi_regulator_i (
		.clk10MHz_inv(clk10MHz_inv), .rst_n(rst_n), .theta(theta),
		.theta_valid(theta_valid), .run(run), .setpoint_load(setpoint_load),
		.setpoint(setpoint), .increment(increment)
	);

	// host access to lock, phase and tuning state
	wb_status_regs #(.START_POINT(START_POINT)) wb_status_regs_i (
		.clk10MHz_inv(clk10MHz_inv), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
		.wb_we(wb_we), .wb_adr(wb_adr), .wb_wdata(wb_wdata), .locked(locked),
		.theta(theta), .increment(increment), .wb_rdata(wb_rdata), .wb_ack(wb_ack),
		.run(run), .setpoint(setpoint), .setpoint_load(setpoint_load)
	);

endmodule

//--- design/wb_map_pkg.sv
package wb_map_pkg;

	// bus widths
	localparam int ADR_W = 2;
	localparam int DAT_W = 16;

	// register map
	localparam logic [ADR_W-1:0] ADR_STATUS = 2'd0;
	localparam logic [ADR_W-1:0] ADR_THETA = 2'd1;
	localparam logic [ADR_W-1:0] ADR_INCREMENT = 2'd2;
	localparam logic [ADR_W-1:0] ADR_SETPOINT = 2'd3;

	// status fields
	// locked is read-only
	localparam int STATUS_LOCKED_BIT = 0;
	// run is read/write
	localparam int STATUS_RUN_BIT = 1;

endpackage

//--- design/wb_status_regs.sv
`timescale 1ns/1ps

module wb_status_regs #(
	parameter logic [osc_cfg_pkg::INC_W-1:0] START_POINT = osc_cfg_pkg::START_POINT
) (
	input  logic                                   clk10MHz_inv,
	input  logic                                   rst_n,
	input  logic                                   wb_cyc,
	input  logic                                   wb_stb,
	input  logic                                   wb_we,
	input  logic [wb_map_pkg::ADR_W-1:0]           wb_adr,
	input  logic [wb_map_pkg::DAT_W-1:0]           wb_wdata,
	input  logic                                   locked,
	input  logic signed [osc_cfg_pkg::THETA_W-1:0] theta,
	input  logic [osc_cfg_pkg::INC_W-1:0]          increment,
	output logic [wb_map_pkg::DAT_W-1:0]           wb_rdata,
	output logic                                   wb_ack,
	output logic                                   run,
	output logic [osc_cfg_pkg::INC_W-1:0]          setpoint,
	output logic                                   setpoint_load
);

	localparam int DAT_W = wb_map_pkg::DAT_W;
	localparam int INC_W = osc_cfg_pkg::INC_W;
	localparam int THETA_W = osc_cfg_pkg::THETA_W;

	logic req;
	logic wr;
	logic [DAT_W-1:0] rd_mux;

	// new request, not the tail of one already acked
	assign req = wb_cyc && wb_stb && !wb_ack;
	assign wr = req && wb_we;

	always_comb begin
		rd_mux = '0;
		case (wb_adr)
			wb_map_pkg::ADR_STATUS: begin
				rd_mux[wb_map_pkg::STATUS_LOCKED_BIT] = locked;
				rd_mux[wb_map_pkg::STATUS_RUN_BIT] = run;
			end
			// sign extended
			wb_map_pkg::ADR_THETA: rd_mux = {{(DAT_W - THETA_W){theta[THETA_W-1]}}, theta};
			wb_map_pkg::ADR_INCREMENT: rd_mux = {{(DAT_W - INC_W){1'b0}}, increment};
			wb_map_pkg::ADR_SETPOINT: rd_mux = {{(DAT_W - INC_W){1'b0}}, setpoint};
			default: rd_mux = '0;
		endcase
	end

	// single-cycle ack, writes land on the same edge
	always_ff @(posedge clk10MHz_inv) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			run <= 1'b0;
			setpoint <= START_POINT;
			setpoint_load <= 1'b0;
		end else begin
			wb_ack <= req;
			setpoint_load <= wr && (wb_adr == wb_map_pkg::ADR_SETPOINT);
			if (wr && wb_adr == wb_map_pkg::ADR_STATUS)
				run <= wb_wdata[wb_map_pkg::STATUS_RUN_BIT];
			if (wr && wb_adr == wb_map_pkg::ADR_SETPOINT)
				setpoint <= wb_wdata[INC_W-1:0];
		end
	end

	// read data valid while ack is high
	always_ff @(posedge clk10MHz_inv) begin
		if (req)
			wb_rdata <= rd_mux;
	end

	a_ack_after_req : assert property (@(posedge clk10MHz_inv) disable iff (!rst_n)
		wb_ack |-> $past(wb_cyc && wb_stb) && !$past(wb_ack))
		else $error("wb_ack without a request on the previous clock");

endmodule

//--- relay_osc.f
design/osc_cfg_pkg.sv
design/wb_map_pkg.sv
design/ico.sv
design/phase_meter.sv
design/lock_detector.sv
design/pi_regulator.sv
design/wb_status_regs.sv
design/relay_osc_top.sv
test/relay_osc_tb.sv

//--- test/relay_osc_tb.sv
`timescale 1ns/1ps

module relay_osc_tb;

	localparam int CLK_NS = 100;
	localparam int PERIOD_CLKS = 695;
	localparam int ACK_LIMIT = 8;
	// oscillator periods held per model setting
	localparam int SETTLE = 5;
	localparam int STEP_WAIT = osc_cfg_pkg::UPDATE_CYCLES + 3;
	// bus and set-point, phase sign, four lock steps, two regulator runs
	localparam int TOTAL_PERIODS = 4 + 2 * SETTLE + 4 * SETTLE + 3 * SETTLE + 2 * STEP_WAIT;
	localparam longint WATCHDOG_NS = longint'(TOTAL_PERIODS) * PERIOD_CLKS * CLK_NS * 3 / 2;
	localparam int TH_MAX = (1 << (osc_cfg_pkg::THETA_W - 1)) - 1;

	logic clk10MHz_inv;
	logic rst_n = 1'b0;
	logic current_sign = 1'b0;
	logic cycle;
	logic locked;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [1:0] wb_adr;
	logic [15:0] wb_wdata;
	logic [15:0] wb_rdata;
	logic wb_ack;

	int check_errors = 0;
	int monitor_errors = 0;
	int bus_errors = 0;
	logic [31:0] lcg_state = 32'h6da5;
	// current model: cycle delayed by delay clocks, optionally inverted
	int delay = 0;
	logic invert = 1'b0;
	int model_gen = 0;
	// +1 increment may only rise, -1 only fall, 0 unchecked
	int inc_dir = 0;
	logic [15:0] rd;
	logic [15:0] sp;

	relay_osc_top relay_osc_top_i (.*);

	initial begin
		clk10MHz_inv = 1'b0;
		forever #(CLK_NS / 2) clk10MHz_inv = ~clk10MHz_inv;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	function automatic int clip_theta(input int v);
		if (v > TH_MAX)
			return TH_MAX;
		if (v < -TH_MAX - 1)
			return -TH_MAX - 1;
		return v;
	endfunction

	// one classic cycle, stb dropped on the clock after ack
	task automatic bus_transfer(input logic we, input logic [1:0] adr,
		input logic [15:0] wdata, output logic [15:0] rdata);
		int waited;
		waited = 0;
		@(negedge clk10MHz_inv);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_wdata = wdata;
		@(negedge clk10MHz_inv);
		while (!wb_ack && waited < ACK_LIMIT) begin
			waited++;
			@(negedge clk10MHz_inv);
		end
		if (!wb_ack) begin
			check_errors++;
			$display("no wb_ack within %0d clocks at address %0d", ACK_LIMIT, adr);
		end
		rdata = wb_rdata;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic read_reg(input logic [1:0] adr, output logic [15:0] data);
		bus_transfer(1'b0, adr, 16'h0, data);
	endtask

	task automatic write_reg(input logic [1:0] adr, input logic [15:0] data);
		logic [15:0] unused;
		bus_transfer(1'b1, adr, data, unused);
	endtask

	task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] want);
		assert (got === want) else begin
			check_errors++;
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, want);
		end
	endtask

	task automatic check_bound(input string name, input logic [15:0] got, input bit ok,
		input logic [15:0] limit);
		assert (ok) else begin
			check_errors++;
			$display("** Error: %s = 0x%h, on the wrong side of 0x%h", name, got, limit);
		end
	endtask

	task automatic set_model(input int d, input logic inv);
		delay = d;
		invert = inv;
		model_gen++;
	endtask

	task automatic wait_periods(input int n);
		repeat (n) @(posedge relay_osc_top_i.theta_valid);
	endtask

	// theta magnitude lands in [lo, hi), then the lock flag is read
	task automatic lock_step(input int d, input int lo, input int hi, input logic want);
		int mag;
		logic [15:0] data;
		// polarity kept so a mixed period falls between old and new theta
		set_model(d, invert);
		wait_periods(SETTLE);
		read_reg(wb_map_pkg::ADR_THETA, data);
		mag = $signed(data) < 0 ? -$signed(data) : $signed(data);
		check_bound("THETA", data, mag >= lo && mag < hi, 16'(lo));
		read_reg(wb_map_pkg::ADR_STATUS, data);
		check_value("STATUS.locked", {15'b0, data[0]}, {15'b0, want});
	endtask

	a_ack_next : assert property (@(posedge clk10MHz_inv) disable iff (!rst_n)
		(wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
		else begin
			bus_errors++;
			$display("wb_ack did not follow a request by one clock");
		end

	a_ack_once : assert property (@(posedge clk10MHz_inv) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
		else begin
			bus_errors++;
			$display("wb_ack stayed high for more than one clock");
		end

	// current model, port high-time meter and per-period checks
	always @(negedge clk10MHz_inv) begin : model_and_monitor
		logic [255:0] hist;
		int hi_cnt;
		int last_high;
		int seen_gen;
		int settle;
		int th;
		int mag;
		int want;
		logic exp_locked;
		logic [14:0] prev_inc;
		logic [14:0] inc;
		if (!rst_n) begin
			hist = '0;
			current_sign = 1'b0;
			hi_cnt = 0;
			last_high = 0;
			seen_gen = model_gen;
			settle = 0;
			exp_locked = 1'b0;
			prev_inc = osc_cfg_pkg::START_POINT;
		end else begin
			hist = {hist[254:0], cycle};
			current_sign = hist[delay] ^ invert;
			// locked moves one clock after theta_valid
			assert (locked === exp_locked) else begin
				monitor_errors++;
				$display("** Error: locked = 0x%h, expected 0x%h", locked, exp_locked);
			end
			if (relay_osc_top_i.theta_valid) begin
				th = relay_osc_top_i.theta;
				mag = th < 0 ? -th : th;
				if (mag < osc_cfg_pkg::THETA_LOWER)
					exp_locked = 1'b1;
				else if (mag >= osc_cfg_pkg::THETA_UPPER)
					exp_locked = 1'b0;
				// first period after a model change is mixed
				if (model_gen != seen_gen) begin
					seen_gen = model_gen;
					settle = 0;
				end else if (settle < 1) begin
					settle++;
				end else begin
					want = clip_theta(invert ? 2 * delay - last_high : last_high - 2 * delay);
					assert (th == want) else begin
						monitor_errors++;
						$display("** Error: theta = 0x%h, expected 0x%h", th, want);
					end
				end
			end
			// high run length, closed when cycle falls
			if (cycle) begin
				hi_cnt++;
			end else begin
				if (hi_cnt != 0)
					last_high = hi_cnt;
				hi_cnt = 0;
			end
			inc = relay_osc_top_i.increment;
			assert (inc_dir == 0 || (inc_dir > 0 ? inc >= prev_inc : inc <= prev_inc))
				else begin
				monitor_errors++;
				$display("** Error: increment = 0x%h, previous 0x%h", inc, prev_inc);
			end
			prev_inc = inc;
		end
	end

	initial begin
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_wdata = '0;
		repeat (5) @(posedge clk10MHz_inv);
		@(negedge clk10MHz_inv);
		rst_n = 1'b1;

		// reset values
		check_value("locked", {15'b0, locked}, 16'h0);
		check_value("wb_ack", {15'b0, wb_ack}, 16'h0);
		read_reg(wb_map_pkg::ADR_STATUS, rd);
		check_value("STATUS", rd, 16'h0);
		read_reg(wb_map_pkg::ADR_INCREMENT, rd);
		check_value("INCREMENT", rd, osc_cfg_pkg::START_POINT);
		read_reg(wb_map_pkg::ADR_SETPOINT, rd);
		check_value("SETPOINT", rd, osc_cfg_pkg::START_POINT);

		// random set-point, open loop follows it
		sp = 16'(20000 + next_rand() % 8000);
		write_reg(wb_map_pkg::ADR_SETPOINT, sp);
		read_reg(wb_map_pkg::ADR_SETPOINT, rd);
		check_value("SETPOINT", rd, sp);
		read_reg(wb_map_pkg::ADR_INCREMENT, rd);
		check_value("INCREMENT", rd, sp);
		wait_periods(2);
		write_reg(wb_map_pkg::ADR_SETPOINT, osc_cfg_pkg::START_POINT);

		// in phase then inverted
		set_model(0, 1'b0);
		wait_periods(SETTLE);
		read_reg(wb_map_pkg::ADR_THETA, rd);
		check_bound("THETA", rd, $signed(rd) >= osc_cfg_pkg::THETA_UPPER, 16'd40);
		set_model(0, 1'b1);
		wait_periods(SETTLE);
		read_reg(wb_map_pkg::ADR_THETA, rd);
		check_bound("THETA", rd, $signed(rd) <= -osc_cfg_pkg::THETA_UPPER, -16'd40);

		// set, hold, clear, hold
		lock_step(168 + next_rand() % 4, 0, 16, 1'b1);
		lock_step(156 + next_rand() % 4, 16, 40, 1'b1);
		lock_step(140 + next_rand() % 8, 40, TH_MAX + 2, 1'b0);
		lock_step(156 + next_rand() % 4, 16, 40, 1'b0);

		// positive theta raises the tuning word
		set_model(0, 1'b0);
		wait_periods(SETTLE);
		write_reg(wb_map_pkg::ADR_STATUS, 16'h2);
		inc_dir = 1;
		wait_periods(STEP_WAIT);
		read_reg(wb_map_pkg::ADR_INCREMENT, rd);
		check_bound("INCREMENT", rd, rd > osc_cfg_pkg::START_POINT, osc_cfg_pkg::START_POINT);
		inc_dir = 0;
		write_reg(wb_map_pkg::ADR_STATUS, 16'h0);
		read_reg(wb_map_pkg::ADR_INCREMENT, rd);
		check_value("INCREMENT", rd, osc_cfg_pkg::START_POINT);

		// negative theta lowers it
		set_model(0, 1'b1);
		wait_periods(SETTLE);
		write_reg(wb_map_pkg::ADR_STATUS, 16'h2);
		inc_dir = -1;
		wait_periods(STEP_WAIT);
		read_reg(wb_map_pkg::ADR_INCREMENT, rd);
		check_bound("INCREMENT", rd, rd < osc_cfg_pkg::START_POINT, osc_cfg_pkg::START_POINT);
		inc_dir = 0;
		write_reg(wb_map_pkg::ADR_STATUS, 16'h0);
		read_reg(wb_map_pkg::ADR_INCREMENT, rd);
		check_value("INCREMENT", rd, osc_cfg_pkg::START_POINT);

		$display("errors: %0d check, %0d monitor, %0d bus", check_errors, monitor_errors,
			bus_errors);
		if (check_errors == 0 && monitor_errors == 0 && bus_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// bound on total run time
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the test sequence did not complete",
			WATCHDOG_NS);
		$display("errors: %0d check, %0d monitor, %0d bus", check_errors, monitor_errors,
			bus_errors);
		$display("TEST FAILED");
		$finish;
	end

endmodule
